/* rtl/tnoc_pkg.sv */
package tnoc_pkg;

  localparam int DATA_WIDTH  = 32;
  localparam int MAX_PAYLOAD = 4;  // payload flits per packet at most
  localparam int PORTS       = 2;
  localparam int FIFO_DEPTH  = 4;  // depth of the lane FIFO unless an instance sets its own

  // widths that carry a meaning of their own
  typedef logic [DATA_WIDTH-1:0]          tnoc_data_t;
  typedef logic [$clog2(PORTS)-1:0]       tnoc_dest_t;
  typedef logic [3:0]                     tnoc_tag_t;
  typedef logic [$clog2(MAX_PAYLOAD)-1:0] tnoc_len_t;  // payload flits minus one

  // one write request as the packetizer takes it in
  // payload[0] leaves the lane first and payload[len] is the last word of the packet
  typedef struct packed {
    tnoc_dest_t                   dest;
    tnoc_tag_t                    tag;
    tnoc_len_t                    len;
    tnoc_data_t [MAX_PAYLOAD-1:0] payload;
  } tnoc_req_t;

  // one flit on any link of the lane
  // a header flit carries its routing fields in the low data bits
  //   bit 0      dest
  //   bits 4..1  tag
  //   bits 6..5  len
  // and zeros in every bit above
  typedef struct packed {
    logic       head;
    logic       tail;
    tnoc_data_t data;
  } tnoc_flit_t;

  // packetizer FSM
  // HEAD holds the header flit and BODY walks the payload words
  typedef enum logic [1:0] {
    IDLE,
    HEAD,
    BODY
  } tnoc_pack_state_e;

endpackage

/* rtl/tnoc_packetizer.sv */
`timescale 1ns/1ps

module tnoc_packetizer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  tnoc_pkg::tnoc_req_t  req,
  input  logic                 req_valid,
  output logic                 req_ready,
  output tnoc_pkg::tnoc_flit_t flit,
  output logic                 flit_valid,
  input  logic                 flit_ready
);
  import tnoc_pkg::*;

  tnoc_pack_state_e state;
  tnoc_pack_state_e state_next;
  tnoc_req_t        req_q;
  tnoc_len_t        idx;      // payload word on the link while in BODY
  logic             accept;
  logic             flit_xfer;
  logic             last;

  assign accept    = req_valid && req_ready;
  assign flit_xfer = flit_valid && flit_ready;
  assign last      = (idx == req_q.len);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = HEAD;
        end
      end
      HEAD: begin
        if (flit_xfer) begin
          state_next = BODY;
        end
      end
      BODY: begin
        if (flit_xfer && last) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      idx       <= '0;
      req_ready <= 1'b0;
    end else begin
      state     <= state_next;
      req_ready <= (state_next == IDLE);  // one request in flight at a time
      if (accept) begin
        idx <= '0;
      end else if ((state == BODY) && flit_xfer && !last) begin
        idx <= idx + 1'b1;
      end
    end
  end

  // the request stays here until its tail has left
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
  end

  // valid comes from the state register alone
  assign flit_valid = (state != IDLE);

  always_comb begin
    flit = '0;
    case (state)
      HEAD: begin
        flit.head      = 1'b1;
        flit.data[0]   = req_q.dest;
        flit.data[4:1] = req_q.tag;
        flit.data[6:5] = req_q.len;
      end
      BODY: begin
        flit.data = req_q.payload[idx];
        flit.tail = last;
      end
      default: begin
        flit = '0;
      end
    endcase
  end

endmodule

/* rtl/tnoc_flit_fifo.sv */
`timescale 1ns/1ps

module tnoc_flit_fifo #(
  parameter int DEPTH = tnoc_pkg::FIFO_DEPTH
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  tnoc_pkg::tnoc_flit_t in_flit,
  input  logic                 in_valid,
  output logic                 in_ready,
  output tnoc_pkg::tnoc_flit_t out_flit,
  output logic                 out_valid,
  input  logic                 out_ready
);
  import tnoc_pkg::*;

  tnoc_flit_t                 mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       full;
  logic                       wr_en;
  logic                       rd_en;

  assign full      = (count == $bits(count)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];

  // a full FIFO still takes a flit when the head leaves in the same cycle
  assign in_ready = !full || out_ready;

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == $bits(wr_ptr)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == $bits(rd_ptr)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/tnoc_route_demux.sv */
`timescale 1ns/1ps

module tnoc_route_demux (
  input  logic                       clk,
  input  logic                       rst_n,
  input  tnoc_pkg::tnoc_flit_t       in_flit,
  input  logic                       in_valid,
  output logic                       in_ready,
  output tnoc_pkg::tnoc_flit_t       out_flit,
  output logic [tnoc_pkg::PORTS-1:0] out_valid,
  input  logic [tnoc_pkg::PORTS-1:0] out_ready
);
  import tnoc_pkg::*;

  tnoc_dest_t route_q;  // port held by the packet in flight
  tnoc_dest_t hdr_dest;
  tnoc_dest_t sel;
  logic       busy;     // set from header transfer until tail transfer
  logic       xfer;

  assign hdr_dest = in_flit.data[$bits(tnoc_dest_t)-1:0];

  // a header picks its port directly and later flits follow the stored route
  always_comb begin
    if (busy) begin
      sel = route_q;
    end else begin
      sel = hdr_dest;
    end
  end

  // the flit bus is shared and only the selected port sees valid
  assign out_flit = in_flit;

  always_comb begin
    for (int p = 0; p < PORTS; p++) begin
      out_valid[p] = in_valid && (sel == tnoc_dest_t'(p));
    end
  end

  assign in_ready = out_ready[sel];  // a stall on the chosen port stalls the FIFO
  assign xfer     = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      route_q <= '0;
    end else if (xfer) begin
      if (in_flit.head) begin
        busy    <= !in_flit.tail;
        route_q <= sel;
      end else if (in_flit.tail) begin
        busy <= 1'b0;  // the wormhole is released so the next header may pick either port
      end
    end
  end

endmodule

/* rtl/tnoc_lane.sv */
`timescale 1ns/1ps

module tnoc_lane (
  input  logic                       clk,
  input  logic                       rst_n,
  input  tnoc_pkg::tnoc_req_t        req,
  input  logic                       req_valid,
  output logic                       req_ready,
  output tnoc_pkg::tnoc_flit_t       out_flit,
  output logic [tnoc_pkg::PORTS-1:0] out_valid,
  input  logic [tnoc_pkg::PORTS-1:0] out_ready
);
  import tnoc_pkg::*;

  // packetizer to FIFO
  tnoc_flit_t pk_flit;
  logic       pk_valid;
  logic       pk_ready;

  // FIFO to route demux
  tnoc_flit_t fifo_flit;
  logic       fifo_valid;
  logic       fifo_ready;

  tnoc_packetizer tnoc_packetizer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .flit       (pk_flit),
    .flit_valid (pk_valid),
    .flit_ready (pk_ready)
  );

  tnoc_flit_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) tnoc_flit_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (pk_flit),
    .in_valid  (pk_valid),
    .in_ready  (pk_ready),
    .out_flit  (fifo_flit),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  tnoc_route_demux tnoc_route_demux_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (fifo_flit),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

/* dv/tnoc_lane_checker.sv */
`timescale 1ns/1ps

module tnoc_lane_checker (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       req_ready,
  input logic                       pk_valid,
  input tnoc_pkg::tnoc_flit_t       out_flit,
  input logic [tnoc_pkg::PORTS-1:0] out_valid,
  input logic [tnoc_pkg::PORTS-1:0] out_ready
);
  import tnoc_pkg::*;

  // a stalled port keeps its flit until the transfer
  for (genvar p = 0; p < PORTS; p++) begin : g_port
    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_flit))
      else $error("port %0d dropped or changed a stalled flit", p);
  end

  a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(out_valid))
    else $error("more than one out_valid bit is high");

  // the packetizer takes no request while its flits are still on the link
  a_busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    pk_valid |-> !req_ready)
    else $error("req_ready high while a packet is being sent");

  a_reset_idle: assert property (@(posedge clk)
    !rst_n |-> out_valid == '0)
    else $error("out_valid high during reset");

endmodule

bind tnoc_lane tnoc_lane_checker tnoc_lane_checker_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_ready (req_ready),
  .pk_valid  (pk_valid),
  .out_flit  (out_flit),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

/* dv/tb_tnoc_lane.sv */
`timescale 1ns/1ps

module tb_tnoc_lane;
  import tnoc_pkg::*;

  localparam int RANDOM_PACKETS  = 60;
  localparam int PLANNED_PACKETS = RANDOM_PACKETS + 2;
  localparam int CYCLE_LIMIT     = 40 * PLANNED_PACKETS + 200;

  typedef tnoc_flit_t flit_q_t [$];

  logic             clk;
  logic             rst_n;
  tnoc_req_t        req;
  logic             req_valid;
  logic             req_ready;
  tnoc_flit_t       out_flit;
  logic [PORTS-1:0] out_valid;
  logic [PORTS-1:0] out_ready;

  flit_q_t exp_q0;  // flits still owed to port 0 in arrival order
  flit_q_t exp_q1;
  int      monitor_errors;
  int      flow_errors;
  int      cycles;
  int      seed_ret;
  bit      stall_en;
  bit      traffic_started;

  tnoc_lane tnoc_lane_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reference model of one packet with the header first and the tail on the last payload word
  function automatic flit_q_t packet_flits(input tnoc_req_t r);
    flit_q_t    flits;
    tnoc_flit_t f;
    f.head = 1'b1;
    f.tail = 1'b0;
    f.data = DATA_WIDTH'({r.len, r.tag, r.dest});
    flits.push_back(f);
    for (int k = 0; k <= int'(r.len); k++) begin
      f.head = 1'b0;
      f.tail = (k == int'(r.len));
      f.data = r.payload[k];
      flits.push_back(f);
    end
    return flits;
  endfunction

  function automatic tnoc_req_t random_req(input tnoc_dest_t dest, input tnoc_len_t len);
    tnoc_req_t r;
    r.dest = dest;
    r.tag  = tnoc_tag_t'($urandom);
    r.len  = len;
    for (int k = 0; k < MAX_PAYLOAD; k++) begin
      r.payload[k] = $urandom;
    end
    return r;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic queue_expected(input tnoc_req_t r);
    flit_q_t flits;
    flits = packet_flits(r);
    foreach (flits[i]) begin
      if (r.dest == 1'b0) begin
        exp_q0.push_back(flits[i]);
      end else begin
        exp_q1.push_back(flits[i]);
      end
    end
  endtask

  // holds the request until the edge where req_ready takes it
  task automatic send_req(input tnoc_req_t r);
    bit accepted;
    accepted = 1'b0;
    queue_expected(r);
    traffic_started = 1'b1;
    req             = r;
    req_valid       = 1'b1;
    while (!accepted) begin
      @(posedge clk);
      accepted = req_ready;
    end
    #1;
    req_valid = 1'b0;
    req       = '0;
  endtask

  task automatic wait_drain();
    while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      step();
    end
    repeat (2) step();
  endtask

  task automatic report_result(input bit timed_out);
    int missing;
    int total;
    missing = exp_q0.size() + exp_q1.size();
    if (exp_q0.size() != 0) begin
      $display("port 0 never delivered %0d expected flits", exp_q0.size());
    end
    if (exp_q1.size() != 0) begin
      $display("port 1 never delivered %0d expected flits", exp_q1.size());
    end
    total = monitor_errors + flow_errors + missing + int'(timed_out);
    $display("monitor errors %0d, flow errors %0d, missing flits %0d, timeout %0d",
             monitor_errors, flow_errors, missing, int'(timed_out));
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
  endtask

  // out_ready per port with random stalls only in the traffic test
  initial begin
    out_ready = '0;
    forever begin
      step();
      if (!rst_n) begin
        out_ready = '0;
      end else if (stall_en) begin
        out_ready[0] = ($urandom_range(0, 3) != 0);
        out_ready[1] = ($urandom_range(0, 3) != 0);
      end else begin
        out_ready = '1;
      end
    end
  end

  // compares every transferred flit against the queue of its port
  initial begin
    tnoc_flit_t       exp_flit;
    bit               have_exp;
    logic [PORTS-1:0] in_packet;
    in_packet = '0;
    forever begin
      @(posedge clk);
      if (!traffic_started && out_valid != '0) begin
        monitor_errors++;
        $display("ERR %0t out_valid went high before any request was sent", $time);
      end
      for (int p = 0; p < PORTS; p++) begin
        if (out_valid[p] && out_ready[p]) begin
          have_exp = 1'b0;
          if (p == 0 && exp_q0.size() != 0) begin
            exp_flit = exp_q0.pop_front();
            have_exp = 1'b1;
          end else if (p == 1 && exp_q1.size() != 0) begin
            exp_flit = exp_q1.pop_front();
            have_exp = 1'b1;
          end
          if (!have_exp) begin
            monitor_errors++;
            $display("ERR %0t port %0d: flit %09h arrived with nothing expected",
                     $time, p, out_flit);
          end else if (out_flit != exp_flit) begin
            monitor_errors++;
            $display("ERR %0t port %0d: got head %0b tail %0b data %08h, expected %0b %0b %08h",
                     $time, p, out_flit.head, out_flit.tail, out_flit.data,
                     exp_flit.head, exp_flit.tail, exp_flit.data);
          end
          if (out_flit.head && in_packet[p]) begin
            monitor_errors++;
            $display("ERR %0t port %0d: header inside an open packet", $time, p);
          end
          if (out_flit.head) begin
            in_packet[p] = !out_flit.tail;
          end else if (out_flit.tail) begin
            in_packet[p] = 1'b0;
          end
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the lane did not finish within %0d cycles", CYCLE_LIMIT);
    report_result(1'b1);
    $finish;
  end

  initial begin
    seed_ret        = $urandom(55);
    rst_n           = 1'b0;
    req             = '0;
    req_valid       = 1'b0;
    stall_en        = 1'b0;
    traffic_started = 1'b0;
    monitor_errors  = 0;
    flow_errors     = 0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (6) step();  // the monitor watches out_valid on the idle lane

    send_req(random_req(tnoc_dest_t'(0), tnoc_len_t'(0)));
    wait_drain();
    send_req(random_req(tnoc_dest_t'(1), tnoc_len_t'(3)));
    wait_drain();

    stall_en = 1'b1;
    for (int i = 0; i < RANDOM_PACKETS; i++) begin
      repeat ($urandom_range(0, 2)) step();
      send_req(random_req(tnoc_dest_t'($urandom_range(0, PORTS - 1)),
                          tnoc_len_t'($urandom_range(0, MAX_PAYLOAD - 1))));
    end
    wait_drain();
    stall_en = 1'b0;
    step();
    if (!req_ready) begin
      flow_errors++;
      $display("ERR %0t req_ready stayed low after all traffic drained", $time);
    end
    report_result(1'b0);
    $finish;
  end

endmodule

/* project.f */
rtl/tnoc_pkg.sv
rtl/tnoc_packetizer.sv
rtl/tnoc_flit_fifo.sv
rtl/tnoc_route_demux.sv
rtl/tnoc_lane.sv
dv/tnoc_lane_checker.sv
dv/tb_tnoc_lane.sv

/* run.sh */
#!/usr/bin/env bash
# build the lane testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_tnoc_lane -f project.f

./obj_dir/Vtb_tnoc_lane | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "run.sh: simulation reported a failure"
  exit 1
fi
echo "run.sh: simulation finished without failures"
